// ==== hw/lb_pkg.sv ====
// Shared bus widths, page numbers and register offsets; page is address bits 23..16
`default_nettype none

package lb_pkg;

	// Local bus
	localparam int LB_AW = 24;
	localparam int LB_DW = 32;
	localparam int PAGE_W = 8;

	// Address pages (bits 23..16)
	localparam logic [PAGE_W-1:0] PAGE_STATUS = 8'd0;
	localparam logic [PAGE_W-1:0] PAGE_LOCAL = 8'd5;
	localparam logic [LB_DW-1:0] BAD_READ_WORD = 32'hdeadbeef;

	// Status bank offsets, low 4 bits of the address
	localparam int REG_OFF_W = 4;
	localparam logic [REG_OFF_W-1:0] REG_HELLO_0 = 4'h0;
	localparam logic [REG_OFF_W-1:0] REG_HELLO_1 = 4'h1;
	localparam logic [REG_OFF_W-1:0] REG_HELLO_2 = 4'h2;
	localparam logic [REG_OFF_W-1:0] REG_HELLO_3 = 4'h3;
	localparam logic [REG_OFF_W-1:0] REG_FAULT_COUNT = 4'h4;
	localparam logic [REG_OFF_W-1:0] REG_FREQ = 4'h5;
	localparam logic [REG_OFF_W-1:0] REG_UPTIME = 4'h6;
	localparam logic [REG_OFF_W-1:0] REG_PINS = 4'h7;

	// Identification words
	localparam logic [LB_DW-1:0] HELLO_0 = "Hell";
	localparam logic [LB_DW-1:0] HELLO_1 = "o wo";
	localparam logic [LB_DW-1:0] HELLO_2 = "rld!";
	localparam logic [LB_DW-1:0] HELLO_3 = "(::)";

	// Mirror memory, also the width of the write offset
	localparam int MIRROR_AW = 5;

	// Write offsets on the local page
	localparam logic [MIRROR_AW-1:0] W_LED_USER = 5'd1;
	localparam logic [MIRROR_AW-1:0] W_LED1_DUTY = 5'd2;
	localparam logic [MIRROR_AW-1:0] W_LED2_DUTY = 5'd3;
	localparam logic [MIRROR_AW-1:0] W_COUNT_CLEAR = 5'd4;
	localparam logic [MIRROR_AW-1:0] W_MISC_CONFIG = 5'd8;

	// Field and counter sizes
	localparam int DUTY_W = 8;
	localparam int MISC_W = 8;
	localparam int PINS_W = 4;
	localparam int LED_CW = 10;
	localparam int FAULT_CW = 16;
	localparam int FREQ_GATE_CW = 10;
	localparam int FREQ_W = 32;

endpackage

`default_nettype wire

// ==== hw/freq_count.sv ====
// Result is meas_clk edges per 1024-cycle clk window, +/-1; first window after reset is invalid
`default_nettype none

module freq_count (
	input wire clk,
	input wire rst,
	input wire meas_clk,
	output logic [lb_pkg::FREQ_W-1:0] freq_value
);
	import lb_pkg::*;

	// Measured clock domain, relies on power-on state only
	logic [FREQ_W-1:0] meas_bin = '0;
	logic [FREQ_W-1:0] meas_gray = '0;
	logic [FREQ_W-1:0] meas_next;

	// clk domain
	logic [FREQ_W-1:0] gray_s1;
	logic [FREQ_W-1:0] gray_s2;
	logic [FREQ_W-1:0] bin_now;
	logic [FREQ_W-1:0] bin_prev;
	logic [FREQ_GATE_CW-1:0] gate_cnt;
	logic gate_end;

	function automatic logic [FREQ_W-1:0] gray_to_bin(input logic [FREQ_W-1:0] g);
		logic [FREQ_W-1:0] b;
		b[FREQ_W-1] = g[FREQ_W-1];
		for (int i = FREQ_W - 2; i >= 0; i--) begin
			b[i] = b[i+1] ^ g[i];
		end
		return b;
	endfunction

	assign meas_next = meas_bin + 1'b1;

	// Gray code tracks the binary count, so only one bit moves per edge
	always_ff @(posedge meas_clk) begin
		meas_bin <= meas_next;
		meas_gray <= meas_next ^ (meas_next >> 1);
	end

	// Two-stage synchronizer into clk
	always_ff @(posedge clk) begin
		gray_s1 <= meas_gray;
		gray_s2 <= gray_s1;
	end

	assign bin_now = gray_to_bin(gray_s2);
	assign gate_end = &gate_cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			gate_cnt <= '0;
			bin_prev <= '0;
			freq_value <= '0;
		end else begin
			gate_cnt <= gate_cnt + 1'b1;
			if (gate_end) begin
				// Wraparound of the difference handles counter rollover
				freq_value <= bin_now - bin_prev;
				bin_prev <= bin_now;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/lb_status_bank.sv ====
// Status word latches on every read strobe whatever the page; fault counter saturates
`default_nettype none

module lb_status_bank (
	input wire clk,
	input wire rst,
	input wire [lb_pkg::LB_AW-1:0] addr,
	input wire control_strobe,
	input wire control_rd,
	input wire xdomain_fault,
	input wire [lb_pkg::PINS_W-1:0] status_pins,
	input wire [lb_pkg::FREQ_W-1:0] freq_value,
	input wire led_tick,
	input wire count_clear,
	output logic [lb_pkg::LB_DW-1:0] status_word
);
	import lb_pkg::*;

	logic do_rd;
	logic [REG_OFF_W-1:0] offset;
	logic [FAULT_CW-1:0] fault_count;
	logic [LB_DW-1:0] uptime;
	logic [PINS_W-1:0] pins_r;

	assign do_rd = control_strobe & control_rd;
	assign offset = addr[REG_OFF_W-1:0];

	// Fault events arrive already in the clk domain
	always_ff @(posedge clk) begin
		if (rst || count_clear) begin
			fault_count <= '0;
		end else if (xdomain_fault && !(&fault_count)) begin
			fault_count <= fault_count + 1'b1;
		end
	end

	// Coarse uptime, one count per PWM period
	always_ff @(posedge clk) begin
		if (rst || count_clear) begin
			uptime <= '0;
		end else if (led_tick) begin
			uptime <= uptime + 1'b1;
		end
	end

	// Pins sampled every cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			pins_r <= '0;
		end else begin
			pins_r <= status_pins;
		end
	end

	// First read cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			status_word <= '0;
		end else if (do_rd) begin
			case (offset)
				REG_HELLO_0: begin
					status_word <= HELLO_0;
				end
				REG_HELLO_1: begin
					status_word <= HELLO_1;
				end
				REG_HELLO_2: begin
					status_word <= HELLO_2;
				end
				REG_HELLO_3: begin
					status_word <= HELLO_3;
				end
				REG_FAULT_COUNT: begin
					status_word <= LB_DW'(fault_count);
				end
				REG_FREQ: begin
					status_word <= LB_DW'(freq_value);
				end
				REG_UPTIME: begin
					status_word <= uptime;
				end
				REG_PINS: begin
					status_word <= LB_DW'(pins_r);
				end
				// Upper half of the bank is unused
				default: begin
					status_word <= '0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/lb_control_regs.sv ====
// Only page 5 writes land here; every such write is also shadowed into the mirror memory
`default_nettype none

module lb_control_regs (
	input wire clk,
	input wire rst,
	input wire [lb_pkg::LB_AW-1:0] addr,
	input wire control_strobe,
	input wire control_rd,
	input wire [lb_pkg::LB_DW-1:0] data_out,
	output logic led_user_mode,
	output logic led1,
	output logic led2,
	output logic [lb_pkg::MISC_W-1:0] misc_config,
	output logic count_clear,
	output logic led_tick,
	output logic [lb_pkg::LB_DW-1:0] mirror_word
);
	import lb_pkg::*;

	logic do_rd;
	logic local_write;
	logic [PAGE_W-1:0] page;
	logic [MIRROR_AW-1:0] waddr;
	logic [DUTY_W-1:0] led1_df;
	logic [DUTY_W-1:0] led2_df;
	logic [LED_CW-1:0] led_cc;

	// Readable copy of everything written to the local page
	logic [LB_DW-1:0] mirror_mem [2**MIRROR_AW];

	assign page = addr[LB_AW-1 -: PAGE_W];
	assign waddr = addr[MIRROR_AW-1:0];
	assign do_rd = control_strobe & control_rd;
	assign local_write = control_strobe & ~control_rd & (page == PAGE_LOCAL);

	// Configuration registers
	always_ff @(posedge clk) begin
		if (rst) begin
			led_user_mode <= 1'b0;
			led1_df <= '0;
			led2_df <= '0;
			misc_config <= '0;
		end else if (local_write) begin
			case (waddr)
				W_LED_USER: begin
					led_user_mode <= data_out[0];
				end
				W_LED1_DUTY: begin
					led1_df <= data_out[DUTY_W-1:0];
				end
				W_LED2_DUTY: begin
					led2_df <= data_out[DUTY_W-1:0];
				end
				W_MISC_CONFIG: begin
					misc_config <= data_out[MISC_W-1:0];
				end
				default: begin
				end
			endcase
		end
	end

	// One-cycle clear pulse for the status counters
	always_ff @(posedge clk) begin
		if (rst) begin
			count_clear <= 1'b0;
		end else begin
			count_clear <= local_write && (waddr == W_COUNT_CLEAR);
		end
	end

	// Free-running PWM counter, carry-out is the uptime tick
	always_ff @(posedge clk) begin
		if (rst) begin
			led_cc <= '0;
			led_tick <= 1'b0;
		end else begin
			{led_tick, led_cc} <= led_cc + 1'b1;
		end
	end

	// High for duty*4 cycles out of 1024
	always_ff @(posedge clk) begin
		if (rst) begin
			led1 <= 1'b0;
			led2 <= 1'b0;
		end else begin
			led1 <= led_cc < {led1_df, 2'b00};
			led2 <= led_cc < {led2_df, 2'b00};
		end
	end

	// Mirror write port
	always_ff @(posedge clk) begin
		if (local_write) begin
			mirror_mem[waddr] <= data_out;
		end
	end

	// Registered read port, fires on any read strobe
	always_ff @(posedge clk) begin
		if (do_rd) begin
			mirror_word <= mirror_mem[waddr];
		end
	end

endmodule

`default_nettype wire

// ==== hw/lb_read_mux.sv ====
// Second read cycle; data_in holds the last read result until the next read
`default_nettype none

module lb_read_mux (
	input wire clk,
	input wire rst,
	input wire [lb_pkg::LB_AW-1:0] addr,
	input wire control_strobe,
	input wire control_rd,
	input wire [lb_pkg::LB_DW-1:0] status_word,
	input wire [lb_pkg::LB_DW-1:0] mirror_word,
	output logic [lb_pkg::LB_DW-1:0] data_in
);
	import lb_pkg::*;

	logic do_rd;
	logic do_rd_r;
	logic [PAGE_W-1:0] page_r;

	assign do_rd = control_strobe & control_rd;

	// Only the page bits are needed a cycle later
	always_ff @(posedge clk) begin
		if (rst) begin
			do_rd_r <= 1'b0;
			page_r <= '0;
		end else begin
			do_rd_r <= do_rd;
			page_r <= addr[LB_AW-1 -: PAGE_W];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			data_in <= '0;
		end else if (do_rd_r) begin
			case (page_r)
				PAGE_STATUS: begin
					data_in <= status_word;
				end
				PAGE_LOCAL: begin
					data_in <= mirror_word;
				end
				// Unmapped page
				default: begin
					data_in <= BAD_READ_WORD;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/lb_slave_top.sv ====
// Two-cycle read latency, no stall; meas_clk is asynchronous to clk
`default_nettype none

module lb_slave_top (
	input wire clk,
	input wire rst,
	input wire [lb_pkg::LB_AW-1:0] addr,
	input wire control_strobe,
	input wire control_rd,
	input wire [lb_pkg::LB_DW-1:0] data_out,
	input wire meas_clk,
	input wire xdomain_fault,
	input wire [lb_pkg::PINS_W-1:0] status_pins,
	output logic [lb_pkg::LB_DW-1:0] data_in,
	output logic led_user_mode,
	output logic led1,
	output logic led2,
	output logic [lb_pkg::MISC_W-1:0] misc_config
);
	import lb_pkg::*;

	logic [LB_DW-1:0] status_word;
	logic [LB_DW-1:0] mirror_word;
	logic [FREQ_W-1:0] freq_value;
	logic led_tick;
	logic count_clear;

	freq_count freq_count_i (
		.clk(clk),
		.rst(rst),
		.meas_clk(meas_clk),
		.freq_value(freq_value)
	);

	lb_status_bank status_bank_i (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.control_strobe(control_strobe),
		.control_rd(control_rd),
		.xdomain_fault(xdomain_fault),
		.status_pins(status_pins),
		.freq_value(freq_value),
		.led_tick(led_tick),
		.count_clear(count_clear),
		.status_word(status_word)
	);

	lb_control_regs control_regs_i (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.control_strobe(control_strobe),
		.control_rd(control_rd),
		.data_out(data_out),
		.led_user_mode(led_user_mode),
		.led1(led1),
		.led2(led2),
		.misc_config(misc_config),
		.count_clear(count_clear),
		.led_tick(led_tick),
		.mirror_word(mirror_word)
	);

	lb_read_mux read_mux_i (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.control_strobe(control_strobe),
		.control_rd(control_rd),
		.status_word(status_word),
		.mirror_word(mirror_word),
		.data_in(data_in)
	);

endmodule

`default_nettype wire

// ==== dv/lb_slave_tb.sv ====
// Assumes the two-cycle read latency; PWM, uptime and frequency checks take thousands of cycles
`default_nettype none

module lb_slave_tb;

	localparam logic [1:0] OP_WR = 2'd0;
	localparam logic [1:0] OP_RD = 2'd1;
	localparam logic [1:0] OP_MISC = 2'd2;
	localparam logic [1:0] OP_LEDU = 2'd3;
	localparam logic [23:0] LOCAL_BASE = 24'h050000;
	localparam logic [31:0] BAD_WORD = 32'hdeadbeef;
	localparam int FREQ_POLL_MAX = 100;

	typedef struct packed {
		logic [1:0] op;
		logic [23:0] adr;
		logic [31:0] wdata;
		logic [31:0] exp_val;
	} stim_t;

	logic clk = 1'b0;
	logic meas_clk = 1'b0;
	logic rst;
	logic [23:0] addr;
	logic control_strobe;
	logic control_rd;
	logic [31:0] data_out;
	logic xdomain_fault;
	logic [3:0] status_pins;
	logic [31:0] data_in;
	logic led_user_mode;
	logic led1;
	logic led2;
	logic [7:0] misc_config;

	stim_t stim_q[$];
	logic [31:0] mirror_exp [32];
	logic [31:0] rng_state;
	int checks = 0;
	int errors = 0;

	always #4 clk = ~clk;
	// Twice the clk period, so 512 edges per gate window
	always #8 meas_clk = ~meas_clk;

	lb_slave_top dut_i (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.control_strobe(control_strobe),
		.control_rd(control_rd),
		.data_out(data_out),
		.meas_clk(meas_clk),
		.xdomain_fault(xdomain_fault),
		.status_pins(status_pins),
		.data_in(data_in),
		.led_user_mode(led_user_mode),
		.led1(led1),
		.led2(led2),
		.misc_config(misc_config)
	);

	function automatic logic [31:0] next_random(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected, input int unsigned tol);
		logic [31:0] diff;
		diff = (actual > expected) ? actual - expected : expected - actual;
		checks++;
		if ((^actual === 1'bx) || (diff > tol)) begin
			errors++;
			$display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic bus_write(input logic [23:0] a, input logic [31:0] d);
		@(posedge clk);
		addr <= a;
		data_out <= d;
		control_rd <= 1'b0;
		control_strobe <= 1'b1;
		@(posedge clk);
		control_strobe <= 1'b0;
		@(negedge clk);
	endtask

	// Result is valid two edges after the edge that samples the strobe
	task automatic bus_read(input logic [23:0] a, output logic [31:0] d);
		@(posedge clk);
		addr <= a;
		control_rd <= 1'b1;
		control_strobe <= 1'b1;
		@(posedge clk);
		control_strobe <= 1'b0;
		control_rd <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		d = data_in;
	endtask

	// Reads on consecutive cycles, each result checked two cycles after its strobe
	task automatic read_burst(input int first, input int n);
		for (int k = 0; k < n + 2; k++) begin
			@(posedge clk);
			if (k < n) begin
				addr <= LOCAL_BASE + 24'(first + k);
				control_rd <= 1'b1;
				control_strobe <= 1'b1;
			end else begin
				control_strobe <= 1'b0;
				control_rd <= 1'b0;
			end
			@(negedge clk);
			if (k >= 2) begin
				check_value($sformatf("data_in burst word %0d", first + k - 2), data_in,
					mirror_exp[first + k - 2], 0);
			end
		end
	endtask

	task automatic add_entry(input logic [1:0] op, input logic [23:0] a,
			input logic [31:0] d, input logic [31:0] e);
		stim_q.push_back('{op: op, adr: a, wdata: d, exp_val: e});
	endtask

	task automatic build_table();
		add_entry(OP_RD, 24'h000000, '0, "Hell");
		add_entry(OP_RD, 24'h000001, '0, "o wo");
		add_entry(OP_RD, 24'h000002, '0, "rld!");
		add_entry(OP_RD, 24'h000003, '0, "(::)");
		add_entry(OP_RD, 24'h000007, '0, 32'h0000000a);
		for (int i = 8; i < 16; i++) begin
			add_entry(OP_RD, 24'(i), '0, '0);
		end
		add_entry(OP_RD, 24'h010000, '0, BAD_WORD);
		add_entry(OP_RD, 24'h020004, '0, BAD_WORD);
		add_entry(OP_RD, 24'h07000c, '0, BAD_WORD);
		// Mirror fill with random words, then readback
		for (int i = 16; i < 32; i++) begin
			rng_state = next_random(rng_state);
			mirror_exp[i] = rng_state;
			add_entry(OP_WR, LOCAL_BASE + 24'(i), rng_state, '0);
		end
		for (int i = 16; i < 32; i++) begin
			add_entry(OP_RD, LOCAL_BASE + 24'(i), '0, mirror_exp[i]);
		end
		add_entry(OP_WR, 24'h050008, 32'hc0de11a5, '0);
		add_entry(OP_MISC, '0, '0, 32'h000000a5);
		add_entry(OP_WR, 24'h050001, 32'h00000003, '0);
		add_entry(OP_LEDU, '0, '0, 32'd1);
		// Page 4 is not the local page
		add_entry(OP_WR, 24'h040008, 32'h0000005a, '0);
		add_entry(OP_MISC, '0, '0, 32'h000000a5);
		add_entry(OP_WR, 24'h040001, 32'h00000000, '0);
		add_entry(OP_LEDU, '0, '0, 32'd1);
		add_entry(OP_WR, 24'h050001, 32'h00000002, '0);
		add_entry(OP_LEDU, '0, '0, 32'd0);
	endtask

	task automatic apply_table();
		stim_t s;
		logic [31:0] rd;
		foreach (stim_q[i]) begin
			s = stim_q[i];
			case (s.op)
				OP_WR: bus_write(s.adr, s.wdata);
				OP_RD: begin
					bus_read(s.adr, rd);
					check_value($sformatf("data_in @%06h", s.adr), rd, s.exp_val, 0);
				end
				OP_MISC: check_value("misc_config", 32'(misc_config), s.exp_val, 0);
				default: check_value("led_user_mode", 32'(led_user_mode), s.exp_val, 0);
			endcase
		end
	endtask

	task automatic measure_pwm(input logic [7:0] d1, input logic [7:0] d2);
		int n1;
		int n2;
		bus_write(24'h050002, 32'(d1));
		bus_write(24'h050003, 32'(d2));
		repeat (4) @(negedge clk);
		n1 = 0;
		n2 = 0;
		repeat (1024) begin
			@(negedge clk);
			n1 += int'(led1);
			n2 += int'(led2);
		end
		check_value("led1 high cycles", 32'(n1), 32'(d1) * 32'd4, 0);
		check_value("led2 high cycles", 32'(n2), 32'(d2) * 32'd4, 0);
	endtask

	task automatic pulse_fault(input int n);
		repeat (n) begin
			@(posedge clk);
			xdomain_fault <= 1'b1;
			@(posedge clk);
			xdomain_fault <= 1'b0;
		end
		@(negedge clk);
	endtask

	task automatic check_counters();
		logic [31:0] rd;
		logic [31:0] u1;
		logic [31:0] u2;
		pulse_fault(3);
		bus_write(24'h050004, '0);
		pulse_fault(7);
		bus_read(24'h000004, rd);
		check_value("fault_count", rd, 32'd7, 0);
		bus_read(24'h000006, u1);
		repeat (1100) @(posedge clk);
		bus_read(24'h000006, u2);
		check_value("uptime increased", 32'(u2 > u1), 32'd1, 0);
	endtask

	task automatic check_frequency();
		logic [31:0] fv;
		int tries;
		fv = '0;
		tries = 0;
		while (fv == 0 && tries < FREQ_POLL_MAX) begin
			bus_read(24'h000005, fv);
			repeat (64) @(posedge clk);
			tries++;
		end
		if (fv == 0) begin
			errors++;
			$display("Timeout: the frequency register never returned a result");
		end else begin
			// Two more windows so the value comes from a clean gate
			repeat (2048) @(posedge clk);
			bus_read(24'h000005, fv);
			check_value("freq_value", fv, 32'd512, 1);
		end
	endtask

	initial begin
		rst = 1'b1;
		addr = '0;
		control_strobe = 1'b0;
		control_rd = 1'b0;
		data_out = '0;
		xdomain_fault = 1'b0;
		status_pins = 4'ha;
		rng_state = 32'd1133;
		build_table();
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_value("data_in after reset", data_in, '0, 0);
		check_value("misc_config after reset", 32'(misc_config), '0, 0);
		apply_table();
		read_burst(16, 16);
		measure_pwm(8'd0, 8'd64);
		measure_pwm(8'd64, 8'd255);
		measure_pwm(8'd255, 8'd0);
		check_counters();
		check_frequency();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== lb_slave.f ====
hw/lb_pkg.sv
hw/freq_count.sv
hw/lb_status_bank.sv
hw/lb_control_regs.sv
hw/lb_read_mux.sv
hw/lb_slave_top.sv
dv/lb_slave_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and decides pass or fail from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module lb_slave_tb -f lb_slave.f -o lb_slave_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/lb_slave_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
	echo "Result: simulation passed"
	exit 0
fi
echo "Result: simulation failed"
exit 1
